// File: project.f
common/cpu_pkg.sv
hw/boot/flash_ctrl.sv
hw/boot/bootloader.sv
hw/core/fetch_unit.sv
hw/core/decoder.sv
hw/core/register_file.sv
hw/core/alu.sv
hw/core/pipe_reg.sv
hw/unified_ram.sv
hw/zhxpu.sv
dv/flash_model.sv
dv/zhxpu_tb.sv

// File: dv/zhxpu_tb.sv
`timescale 1ns/1ps

module zhxpu_tb import cpu_pkg::*; ();

	typedef struct packed {
		logic [word_w-1:0] instr;
		wb_trace_t exp;
	} prog_row_t;

	localparam logic [word_w-1:0] nop_word = '0;

	logic clk;
	logic reset;
	logic [flash_addr_w-1:0] flash_addr;
	logic [word_w-1:0] flash_data;
	logic flash_ce_n;
	logic flash_oe_n;
	logic boot_done;
	wb_trace_t trace;
	logic halted;
	int flash_reads;
	int flash_faults;

	prog_row_t prog [$];
	wb_trace_t exp_trace [$];
	int trace_idx = 0;
	int checks = 0;
	int errors = 0;
	integer seed = 7328;

	zhxpu dut (
		.clk(clk),
		.reset(reset),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n),
		.boot_done(boot_done),
		.trace(trace),
		.halted(halted)
	);

	flash_model fm (
		.addr(flash_addr),
		.ce_n(flash_ce_n),
		.oe_n(flash_oe_n),
		.data(flash_data),
		.read_count(flash_reads),
		.fault_count(flash_faults)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [word_w-1:0] sext8(input logic [7:0] v);
		return {{(word_w - 8){v[7]}}, v};
	endfunction

	function automatic logic [word_w-1:0] enc_imm(input opcode_t op,
			input logic [reg_addr_w-1:0] rx, input logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic logic [word_w-1:0] enc_reg(input opcode_t op,
			input logic [reg_addr_w-1:0] rx, input logic [reg_addr_w-1:0] ry,
			input logic [reg_addr_w-1:0] rz);
		return {op, rx, ry, rz, 2'b00};
	endfunction

	function automatic logic [word_w-1:0] enc_mem(input opcode_t op,
			input logic [reg_addr_w-1:0] rx, input logic [reg_addr_w-1:0] ry,
			input logic [4:0] off);
		return {op, rx, ry, off};
	endfunction

	task automatic add_row(input logic [word_w-1:0] instr, input logic traced,
			input logic [reg_addr_w-1:0] rd, input logic [word_w-1:0] value);
		prog_row_t row;
		row.instr = instr;
		row.exp.valid = traced;
		row.exp.rd = traced ? rd : '0;
		row.exp.value = traced ? value : '0;
		prog.push_back(row);
	endtask

	task automatic build_program();
		logic [7:0] ra;
		logic [7:0] rb;
		logic [word_w-1:0] a;
		logic [word_w-1:0] b;
		logic [word_w-1:0] sum;
		logic [word_w-1:0] slt_exp;
		// Arithmetic
		add_row(enc_imm(op_li, 1, 8'd5), 1, 1, 16'd5);
		add_row(enc_imm(op_li, 2, 8'hfd), 1, 2, sext8(8'hfd));
		add_row(enc_imm(op_li, 3, 8'd12), 1, 3, 16'd12);
		add_row(enc_imm(op_addi, 1, 8'd10), 1, 1, 16'd15);
		add_row(enc_reg(op_add, 4, 2, 3), 1, 4, sext8(8'hfd) + 16'd12);
		add_row(enc_reg(op_sub, 5, 3, 2), 1, 5, 16'd12 - sext8(8'hfd));
		add_row(enc_reg(op_and, 6, 1, 3), 1, 6, 16'd15 & 16'd12);
		add_row(enc_reg(op_slt, 7, 2, 3), 1, 7, 16'd1);
		add_row(enc_reg(op_slt, 7, 3, 2), 1, 7, 16'd0);
		// Random constants
		ra = 8'($random(seed));
		rb = 8'($random(seed));
		a = sext8(ra);
		b = sext8(rb);
		sum = a + b;
		// Negative one is the smaller, same signs order like unsigned
		slt_exp = (ra[7] != rb[7]) ? word_w'(ra[7]) : ((ra < rb) ? 16'd1 : 16'd0);
		add_row(enc_imm(op_li, 1, ra), 1, 1, a);
		add_row(enc_imm(op_li, 2, rb), 1, 2, b);
		add_row(nop_word, 0, 0, 0);
		add_row(enc_reg(op_add, 3, 1, 2), 1, 3, sum);
		add_row(enc_reg(op_sub, 4, 1, 2), 1, 4, a - b);
		add_row(nop_word, 0, 0, 0);
		add_row(enc_reg(op_slt, 5, 1, 2), 1, 5, slt_exp);
		// Store then load at 0x72, outside the image
		add_row(enc_imm(op_li, 6, 8'h70), 1, 6, 16'h0070);
		add_row(nop_word, 0, 0, 0);
		add_row(enc_mem(op_sw, 3, 6, 5'd2), 0, 0, 0);
		add_row(enc_imm(op_li, 0, 8'd0), 1, 0, 16'd0);
		add_row(enc_mem(op_lw, 1, 6, 5'd2), 1, 1, sum);
		add_row(nop_word, 0, 0, 0);
		add_row(enc_imm(op_addi, 1, 8'd1), 1, 1, sum + 16'd1);
		// Branches at 26 and 30 with delay slots
		add_row(enc_imm(op_li, 2, 8'd0), 1, 2, 16'd0);
		add_row(enc_imm(op_li, 3, 8'd7), 1, 3, 16'd7);
		add_row(nop_word, 0, 0, 0);
		add_row(enc_imm(op_beqz, 2, 8'd3), 0, 0, 0);
		add_row(enc_imm(op_li, 4, 8'd33), 1, 4, 16'd33);
		add_row(enc_imm(op_li, 4, 8'd99), 0, 0, 0);
		add_row(enc_imm(op_li, 5, 8'd99), 0, 0, 0);
		add_row(enc_imm(op_beqz, 3, 8'd2), 0, 0, 0);
		add_row(enc_imm(op_li, 5, 8'd44), 1, 5, 16'd44);
		add_row(enc_imm(op_li, 6, 8'd55), 1, 6, 16'd55);
		add_row({op_b, 11'd2}, 0, 0, 0);
		add_row(enc_imm(op_li, 7, 8'd66), 1, 7, 16'd66);
		add_row(enc_imm(op_li, 7, 8'd99), 0, 0, 0);
		add_row(enc_reg(op_add, 0, 4, 5), 1, 0, 16'd33 + 16'd44);
		add_row({op_halt, 11'd0}, 0, 0, 0);
	endtask

	task automatic check_trace(input string name, input wb_trace_t exp, input wb_trace_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %0t %s: expected r%0d=%h valid=%b, actual r%0d=%h valid=%b",
				$time, name, exp.rd, exp.value, exp.valid, act.rd, act.value, act.valid);
		end
	endtask

	task automatic check_word(input string name, input logic [word_w-1:0] exp,
			input logic [word_w-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %0t %s: expected %0d, actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %0t %s: expected %b, actual %b", $time, name, exp, act);
		end
	endtask

	// Write-back events in program order
	always @(negedge clk) begin
		if (!reset && trace.valid === 1'b1) begin
			if (trace_idx < exp_trace.size()) begin
				check_trace("trace", exp_trace[trace_idx], trace);
			end else begin
				errors++;
				$display("Unexpected write-back of r%0d = %h at %0t after the last expected one",
					trace.rd, trace.value, $time);
			end
			trace_idx++;
		end
	end

	initial begin : watchdog
		int limit;
		@(negedge reset);
		limit = boot_words * (flash_wait + 3) + prog.size() * 4 + 200;
		repeat (limit) @(posedge clk);
		$display("Run timed out after %0d cycles without finishing the program", limit);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int i;
		reset = 1'b1;
		build_program();
		for (i = 0; i < boot_words; i++) begin
			fm.image[i] = (i < prog.size()) ? prog[i].instr : nop_word;
		end
		for (i = 0; i < prog.size(); i++) begin
			if (prog[i].exp.valid)
				exp_trace.push_back(prog[i].exp);
		end

		repeat (7) @(posedge clk);
		@(negedge clk);
		check_bit("boot_done", 1'b0, boot_done);
		check_bit("halted", 1'b0, halted);
		check_bit("trace.valid", 1'b0, trace.valid);
		@(posedge clk);
		reset <= 1'b0;

		wait (boot_done === 1'b1);
		@(negedge clk);
		check_word("flash reads at boot_done", word_w'(boot_words), word_w'(flash_reads));

		wait (halted === 1'b1);
		@(negedge clk);
		check_word("trace events at halted", word_w'(exp_trace.size()), word_w'(trace_idx));
		// Nothing may retire once halted
		repeat (20) @(negedge clk);
		check_bit("halted", 1'b1, halted);
		check_word("trace events after halt", word_w'(exp_trace.size()), word_w'(trace_idx));
		check_word("flash reads after boot", word_w'(boot_words), word_w'(flash_reads));
		check_word("flash faults", '0, word_w'(flash_faults));

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: dv/flash_model.sv
`timescale 1ns/1ps

module flash_model import cpu_pkg::*; #(
	parameter int access_ns = 25
) (
	input  logic [flash_addr_w-1:0] addr,
	input  logic ce_n,
	input  logic oe_n,
	output logic [word_w-1:0] data,
	output int read_count,
	output int fault_count
);

	logic [word_w-1:0] image [boot_words];
	logic [flash_addr_w-1:0] read_addr;
	logic reading;

	initial begin
		data = '0;
		read_count = 0;
		fault_count = 0;
		reading = 1'b0;
	end

	// Unknown output until the access time has passed
	always @(addr or ce_n or oe_n) begin
		if (ce_n !== 1'b0 || oe_n !== 1'b0) begin
			data = '0;
		end else begin
			data = 'x;
			data <= #(access_ns) image[addr];
		end
	end

	// Address settles in the same step as ce_n
	always @(negedge ce_n) begin
		#1;
		read_addr = addr;
		reading = 1'b1;
		read_count++;
		if (oe_n !== 1'b0) begin
			fault_count++;
			$display("Flash read started without output enable at %0t", $time);
		end
		if (^addr === 1'bx || addr >= boot_words) begin
			fault_count++;
			$display("Flash read outside the boot image at %0t, address %h", $time, addr);
		end
	end

	always @(posedge ce_n) begin
		reading = 1'b0;
		#1;
		if (oe_n !== 1'b1) begin
			fault_count++;
			$display("Flash output enable still active after the read at %0t", $time);
		end
	end

	always @(addr) begin
		if (reading && addr !== read_addr) begin
			fault_count++;
			$display("Flash address changed during a read at %0t", $time);
		end
	end

endmodule

// File: hw/zhxpu.sv
`timescale 1ns/1ps

module zhxpu import cpu_pkg::*; (
	input  logic clk,
	input  logic reset,
	output logic [flash_addr_w-1:0] flash_addr,
	input  logic [word_w-1:0] flash_data,
	output logic flash_ce_n,
	output logic flash_oe_n,
	output logic boot_done,
	output wb_trace_t trace,
	output logic halted
);

	logic boot_req;
	logic boot_ack;
	logic [flash_addr_w-1:0] boot_flash_addr;
	logic [word_w-1:0] boot_rdata;
	logic boot_we;
	logic [ram_addr_w-1:0] boot_addr;
	logic [word_w-1:0] boot_wdata;

	logic hold;
	logic [word_w-1:0] pc;
	logic [word_w-1:0] fetch_data;
	if_id_t if_d;
	if_id_t id;

	logic [reg_addr_w-1:0] rd_addr1;
	logic [reg_addr_w-1:0] rd_addr2;
	logic [word_w-1:0] rd_data1;
	logic [word_w-1:0] rd_data2;
	id_exe_t id_ctrl;
	logic branch_taken;
	logic [word_w-1:0] branch_target;
	logic halt_seen;

	id_exe_t exe;
	logic [word_w-1:0] alu_result;
	logic [word_w-1:0] exe_rdata;
	exe_wb_t wb_d;
	exe_wb_t wb;

// Boot
	bootloader __bootloader(
		.clk(clk),
		.reset(reset),
		.flash_req(boot_req),
		.flash_addr(boot_flash_addr),
		.flash_ack(boot_ack),
		.flash_rdata(boot_rdata),
		.boot_we(boot_we),
		.boot_addr(boot_addr),
		.boot_wdata(boot_wdata),
		.boot_done(boot_done)
	);

	flash_ctrl __flash_ctrl(
		.clk(clk),
		.reset(reset),
		.req(boot_req),
		.addr(boot_flash_addr),
		.ack(boot_ack),
		.rdata(boot_rdata),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n)
	);

	unified_ram __unified_ram(
		.clk(clk),
		.boot_we(boot_we),
		.boot_addr(boot_addr),
		.boot_wdata(boot_wdata),
		.fetch_addr(pc),
		.fetch_data(fetch_data),
		.exe(exe),
		.exe_addr(alu_result),
		.exe_rdata(exe_rdata),
		.hold(hold)
	);

// IF
	fetch_unit __fetch_unit(
		.clk(clk),
		.reset(reset),
		.enable(boot_done),
		.hold(hold),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.halt_seen(halt_seen),
		.pc(pc)
	);

	assign if_d = '{pc: pc, instr: fetch_data};

	pipe_reg #(.payload_t(if_id_t)) __if_id(
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.bubble(!boot_done),
		.d(if_d),
		.q(id)
	);

// ID
	decoder __decoder(
		.id(id),
		.rd_addr1(rd_addr1),
		.rd_addr2(rd_addr2),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2),
		.ctrl(id_ctrl),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.halt_seen(halt_seen)
	);

	register_file __register_file(
		.clk(clk),
		.reset(reset),
		.rd_addr1(rd_addr1),
		.rd_addr2(rd_addr2),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2),
		.wr(wb)
	);

	pipe_reg #(.payload_t(id_exe_t)) __id_exe(
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.bubble(hold),
		.d(id_ctrl),
		.q(exe)
	);

// EXE
	alu __alu(
		.op(exe.alu_op),
		.a(exe.a),
		.b(exe.b),
		.result(alu_result)
	);

	assign wb_d = '{
		reg_wr: exe.reg_wr,
		dest: exe.dest,
		value: exe.mem_rd ? exe_rdata : alu_result,
		halt: exe.halt
	};

	// A halt parks in WB for good
	pipe_reg #(.payload_t(exe_wb_t)) __exe_wb(
		.clk(clk),
		.reset(reset),
		.hold(wb.halt),
		.bubble(1'b0),
		.d(wb_d),
		.q(wb)
	);

// WB
	assign trace = '{valid: wb.reg_wr, rd: wb.dest, value: wb.value};
	assign halted = wb.halt;

endmodule

// File: hw/unified_ram.sv
`timescale 1ns/1ps

module unified_ram import cpu_pkg::*; (
	input  logic clk,
	input  logic boot_we,
	input  logic [ram_addr_w-1:0] boot_addr,
	input  logic [word_w-1:0] boot_wdata,
	input  logic [word_w-1:0] fetch_addr,
	output logic [word_w-1:0] fetch_data,
	input  id_exe_t exe,
	input  logic [word_w-1:0] exe_addr,
	output logic [word_w-1:0] exe_rdata,
	output logic hold
);

	logic [word_w-1:0] mem [2**ram_addr_w];
	logic [ram_addr_w-1:0] port_addr;
	logic [word_w-1:0] port_wdata;
	logic port_we;
	logic [word_w-1:0] port_rdata;

	// EXE takes the port from fetch for one cycle
	assign hold = exe.mem_rd | exe.mem_wr;

	always_comb begin
		if (boot_we) begin
			port_addr = boot_addr;
		end else if (hold) begin
			port_addr = exe_addr[ram_addr_w-1:0];
		end else begin
			port_addr = fetch_addr[ram_addr_w-1:0];
		end
	end

	assign port_wdata = boot_we ? boot_wdata : exe.store_data;
	assign port_we = boot_we | exe.mem_wr;

	always_ff @(posedge clk) begin
		if (port_we)
			mem[port_addr] <= port_wdata;
	end

	assign port_rdata = mem[port_addr];
	assign fetch_data = port_rdata;
	assign exe_rdata = port_rdata;

	// Pipeline must stay empty until the image is loaded
	a_no_exe_during_boot: assert property (@(posedge clk)
		boot_we |-> !hold);

endmodule

// File: hw/core/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic clk,
	input  logic reset,
	input  logic hold,
	input  logic bubble,
	input  payload_t d,
	output payload_t q
);

	// All zeros decodes as a no-op with no writes
	always_ff @(posedge clk) begin
		if (reset || bubble) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

	a_no_hold_and_bubble: assert property (@(posedge clk) disable iff (reset)
		!(hold && bubble));

endmodule

// File: hw/core/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  alu_op_t op,
	input  logic [word_w-1:0] a,
	input  logic [word_w-1:0] b,
	output logic [word_w-1:0] result
);

	always_comb begin
		case (op)
			// Also the lw/sw address
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_slt: result = ($signed(a) < $signed(b)) ? word_w'(1) : '0;
			alu_pass_b: result = b;
			default: result = '0;
		endcase
	end

endmodule

// File: hw/core/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic [reg_addr_w-1:0] rd_addr1,
	input  logic [reg_addr_w-1:0] rd_addr2,
	output logic [word_w-1:0] rd_data1,
	output logic [word_w-1:0] rd_data2,
	input  exe_wb_t wr
);

	logic [word_w-1:0] regs [2**reg_addr_w];

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (wr.reg_wr) begin
			regs[wr.dest] <= wr.value;
		end
	end

	// Write-back in the same cycle wins over the stored value
	assign rd_data1 = (wr.reg_wr && wr.dest == rd_addr1) ? wr.value : regs[rd_addr1];
	assign rd_data2 = (wr.reg_wr && wr.dest == rd_addr2) ? wr.value : regs[rd_addr2];

endmodule

// File: hw/core/decoder.sv
`timescale 1ns/1ps

module decoder import cpu_pkg::*; (
	input  if_id_t id,
	output logic [reg_addr_w-1:0] rd_addr1,
	output logic [reg_addr_w-1:0] rd_addr2,
	input  logic [word_w-1:0] rd_data1,
	input  logic [word_w-1:0] rd_data2,
	output id_exe_t ctrl,
	output logic branch_taken,
	output logic [word_w-1:0] branch_target,
	output logic halt_seen
);

	opcode_t op;
	logic [reg_addr_w-1:0] rx;
	logic [reg_addr_w-1:0] ry;
	logic [reg_addr_w-1:0] rz;
	logic [word_w-1:0] imm8;
	logic [word_w-1:0] imm5;
	logic [word_w-1:0] imm11;

	assign op = opcode_t'(id.instr[15:11]);
	assign rx = id.instr[10:8];
	assign ry = id.instr[7:5];
	assign rz = id.instr[4:2];

	assign imm8 = {{(word_w - 8){id.instr[7]}}, id.instr[7:0]};
	assign imm5 = {{(word_w - 5){id.instr[4]}}, id.instr[4:0]};
	assign imm11 = {{(word_w - 11){id.instr[10]}}, id.instr[10:0]};

	// addi and beqz read rx, sw sends rx as store data
	assign rd_addr1 = (op == op_addi || op == op_beqz) ? rx : ry;
	assign rd_addr2 = (op == op_sw) ? rx : rz;

	assign branch_target = id.pc + word_w'(1) + ((op == op_b) ? imm11 : imm8);
	assign branch_taken = (op == op_b) || (op == op_beqz && rd_data1 == '0);
	assign halt_seen = (op == op_halt);

	always_comb begin
		ctrl = '0;
		ctrl.a = rd_data1;
		ctrl.b = rd_data2;
		ctrl.dest = rx;
		case (op)
			op_li: begin
				ctrl.alu_op = alu_pass_b;
				ctrl.b = imm8;
				ctrl.reg_wr = 1'b1;
			end
			op_addi: begin
				ctrl.b = imm8;
				ctrl.reg_wr = 1'b1;
			end
			op_add, op_sub, op_and, op_slt: begin
				ctrl.alu_op = (op == op_add) ? alu_add :
				              (op == op_sub) ? alu_sub :
				              (op == op_and) ? alu_and : alu_slt;
				ctrl.reg_wr = 1'b1;
			end
			op_lw: begin
				ctrl.b = imm5;
				ctrl.mem_rd = 1'b1;
				ctrl.reg_wr = 1'b1;
			end
			op_sw: begin
				ctrl.b = imm5;
				ctrl.store_data = rd_data2;
				ctrl.mem_wr = 1'b1;
			end
			op_halt: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

// File: hw/core/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  logic hold,
	input  logic branch_taken,
	input  logic [word_w-1:0] branch_target,
	input  logic halt_seen,
	output logic [word_w-1:0] pc
);

	logic frozen;
	logic pend_valid;
	logic [word_w-1:0] pend_target;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			frozen <= 1'b0;
			pend_valid <= 1'b0;
		end else if (enable && !frozen) begin
			if (halt_seen) begin
				frozen <= 1'b1;
			end else if (hold) begin
				pend_valid <= pend_valid | branch_taken;
			end else if (pend_valid) begin
				pc <= pend_target;
				pend_valid <= 1'b0;
			end else if (branch_taken) begin
				pc <= branch_target;
			end else begin
				pc <= pc + 1'b1;
			end
		end
	end

	// Redirect seen while RAM is busy with EXE
	always_ff @(posedge clk) begin
		if (hold && branch_taken)
			pend_target <= branch_target;
	end

endmodule

// File: hw/boot/bootloader.sv
`timescale 1ns/1ps

module bootloader import cpu_pkg::*; (
	input  logic clk,
	input  logic reset,
	output logic flash_req,
	output logic [flash_addr_w-1:0] flash_addr,
	input  logic flash_ack,
	input  logic [word_w-1:0] flash_rdata,
	output logic boot_we,
	output logic [ram_addr_w-1:0] boot_addr,
	output logic [word_w-1:0] boot_wdata,
	output logic boot_done
);

	typedef enum logic [1:0] {st_request, st_wait_ack, st_wait_release, st_done} state_t;

	state_t state;
	logic [boot_cnt_w-1:0] word_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_request;
			flash_req <= 1'b0;
			word_cnt <= '0;
			boot_done <= 1'b0;
		end else begin
			case (state)
				st_request: if (!flash_ack) begin
					flash_req <= 1'b1;
					state <= st_wait_ack;
				end
				st_wait_ack: if (flash_ack) begin
					flash_req <= 1'b0;
					state <= st_wait_release;
				end
				st_wait_release: if (!flash_ack) begin
					if (word_cnt == boot_cnt_w'(boot_words - 1)) begin
						boot_done <= 1'b1;
						state <= st_done;
					end else begin
						// Next word, address moves with the new request
						word_cnt <= word_cnt + 1'b1;
						flash_req <= 1'b1;
						state <= st_wait_ack;
					end
				end
				default: state <= st_done;
			endcase
		end
	end

	assign flash_addr = boot_flash_base + flash_addr_w'(word_cnt);

	// One RAM write per word, in the ack cycle
	assign boot_we = (state == st_wait_ack) && flash_ack;
	assign boot_addr = ram_addr_w'(word_cnt);
	assign boot_wdata = flash_rdata;

	a_req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
		$rose(flash_req) |-> !flash_ack);

endmodule

// File: hw/boot/flash_ctrl.sv
`timescale 1ns/1ps

module flash_ctrl import cpu_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic [flash_addr_w-1:0] addr,
	output logic ack,
	output logic [word_w-1:0] rdata,
	output logic [flash_addr_w-1:0] flash_addr,
	input  logic [word_w-1:0] flash_data,
	output logic flash_ce_n,
	output logic flash_oe_n
);

	typedef enum logic [1:0] {st_idle, st_wait, st_ack, st_release} state_t;

	state_t state;
	logic [flash_wait_w-1:0] wait_cnt;
	logic wait_last;

	assign wait_last = (wait_cnt == flash_wait_w'(flash_wait - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			ack <= 1'b0;
			flash_ce_n <= 1'b1;
			flash_oe_n <= 1'b1;
			wait_cnt <= '0;
		end else begin
			case (state)
				st_idle: if (req) begin
					flash_ce_n <= 1'b0;
					flash_oe_n <= 1'b0;
					wait_cnt <= '0;
					state <= st_wait;
				end
				st_wait: if (wait_last) begin
					ack <= 1'b1;
					state <= st_ack;
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
				// Hold data until the requester lets go
				st_ack: if (!req) begin
					flash_ce_n <= 1'b1;
					flash_oe_n <= 1'b1;
					ack <= 1'b0;
					state <= st_release;
				end
				// Bus turnaround before the next read
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && req)
			flash_addr <= addr;
		if (state == st_wait && wait_last)
			rdata <= flash_data;
	end

	a_addr_stable: assert property (@(posedge clk) disable iff (reset)
		req && $past(req) |-> addr == $past(addr));

endmodule

// File: common/cpu_pkg.sv
package cpu_pkg;

	localparam int word_w = 16;
	localparam int reg_addr_w = 3;
	localparam int ram_addr_w = 8;
	localparam int flash_addr_w = 22;

	// Boot image, copied word by word from the start of flash
	localparam int boot_words = 64;
	localparam int boot_cnt_w = $clog2(boot_words);
	localparam logic [flash_addr_w-1:0] boot_flash_base = '0;

	// Flash access time in clk cycles
	localparam int flash_wait = 3;
	localparam int flash_wait_w = $clog2(flash_wait + 1);

	// Instruction layout: op[15:11] rx[10:8] ry[7:5] rz[4:2]
	// imm8 is [7:0], imm5 is [4:0], imm11 is [10:0], all sign-extended
	typedef enum logic [4:0] {
		op_nop  = 5'd0,  // no operation
		op_li   = 5'd1,  // rx = imm8
		op_addi = 5'd2,  // rx = rx + imm8
		op_add  = 5'd3,  // rx = ry + rz
		op_sub  = 5'd4,  // rx = ry - rz
		op_and  = 5'd5,  // rx = ry & rz
		op_slt  = 5'd6,  // rx = (ry < rz) signed
		op_lw   = 5'd7,  // rx = mem[ry + imm5]
		op_sw   = 5'd8,  // mem[ry + imm5] = rx
		op_beqz = 5'd9,  // if rx == 0, pc = pc + 1 + imm8
		op_b    = 5'd10, // pc = pc + 1 + imm11
		op_halt = 5'd11
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_slt    = 3'd3,
		alu_pass_b = 3'd4
	} alu_op_t;

	typedef struct packed {
		logic [word_w-1:0] pc;
		logic [word_w-1:0] instr;
	} if_id_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic [word_w-1:0] a;
		logic [word_w-1:0] b;
		logic [word_w-1:0] store_data;
		logic mem_rd;
		logic mem_wr;
		logic reg_wr;
		logic [reg_addr_w-1:0] dest;
		logic halt;
	} id_exe_t;

	typedef struct packed {
		logic reg_wr;
		logic [reg_addr_w-1:0] dest;
		logic [word_w-1:0] value;
		logic halt;
	} exe_wb_t;

	typedef struct packed {
		logic valid;
		logic [reg_addr_w-1:0] rd;
		logic [word_w-1:0] value;
	} wb_trace_t;

endpackage
